// ==== sources.f ====
rtl/regfPkg.sv
rtl/loadAlign.sv
rtl/regFile.sv
rtl/storeAlign.sv
rtl/regfTop.sv
testbench/regfTb_assert.sv
testbench/regfTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = regfTb
FILELIST  = sources.f
SIMFLAGS  = +verilator+error+limit+1000
SIMBIN    = obj_dir/V$(TOP)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIMBIN) $(SIMFLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qF "=== PASS ==="

clean:
	rm -rf obj_dir

// ==== testbench/regfTb.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Data path testbench
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module regfTb import regfPkg::*; ();

   // Test lengths in cycles
   localparam int RST_LEN   = 3;
   localparam int FILL_LEN  = 31;
   localparam int LOAD_LEN  = 40;
   localparam int WRRD_LEN  = 64;
   localparam int R0_LEN    = 12;
   localparam int STORE_LEN = 48;
   localparam int FWD_LEN   = 32;
   localparam int STALL_LEN = 40;
   localparam int TAIL_LEN  = 2;
   localparam int TIMEOUT_CYCLES = 2 * (RST_LEN + FILL_LEN + LOAD_LEN + WRRD_LEN + R0_LEN
                                        + STORE_LEN + FWD_LEN + STALL_LEN + RST_LEN + 1
                                        + 8 * TAIL_LEN);

   logic     gclk;
   logic     grst;
   logic     gena;
   readCtl_t readCtl;
   wbCtl_t   wbCtl;
   laneSel_t laneSel;
   stSize_t  stSize;
   word_t    aluResult;
   word_t    dwbDatIn;
   word_t    fslDatIn;
   word_t    regA;
   word_t    regB;
   word_t    loadData;
   word_t    dwbDatOut;
   word_t    fslDatOut;

   logic [31:0] rngState;
   int          cycleCount = 0;
   int          testCount;
   int          testMark;

   regfTop i_regfTop (
      .gclk        (gclk),
      .grst        (grst),
      .gena        (gena),
      .readCtl_i   (readCtl),
      .wbCtl_i     (wbCtl),
      .laneSel_i   (laneSel),
      .stSize_i    (stSize),
      .aluResult_i (aluResult),
      .dwbDat_i    (dwbDatIn),
      .fslDat_i    (fslDatIn),
      .regA_o      (regA),
      .regB_o      (regB),
      .loadData_o  (loadData),
      .dwbDat_o    (dwbDatOut),
      .fslDat_o    (fslDatOut)
   );

   // Checker sits inside the DUT
   bind regfTop regfTbAssert i_regfTbAssert (
      .gclk(gclk), .grst(grst), .gena(gena), .readCtl_i(readCtl_i), .wbCtl_i(wbCtl_i),
      .laneSel_i(laneSel_i), .stSize_i(stSize_i), .aluResult_i(aluResult_i),
      .dwbDat_i(dwbDat_i), .fslDat_i(fslDat_i), .regA_o(regA_o), .regB_o(regB_o),
      .loadData_o(loadData_o), .dwbDat_o(dwbDat_o), .fslDat_o(fslDat_o)
   );

   initial begin
      gclk = 1'b0;
      forever #4 gclk = ~gclk;
   end

   // Run limit
   always @(posedge gclk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= TIMEOUT_CYCLES) begin
         $display("Timeout: run still busy after %0d cycles", cycleCount);
         $display("=== FAIL ===");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic drawRandom(output word_t w);
      rngState = xorshift32(rngState);
      w = rngState;
   endtask

   function automatic int checkFailures();
      return i_regfTop.i_regfTbAssert.failCount;
   endfunction

   // Codes 0 to 7 legal, 8 and 9 illegal
   function automatic laneSel_t lanePattern(input logic [3:0] n);
      case (n)
         4'd0:    return LANE_B3;
         4'd1:    return LANE_B2;
         4'd2:    return LANE_B1;
         4'd3:    return LANE_B0;
         4'd4:    return LANE_HI;
         4'd5:    return LANE_LO;
         4'd6:    return LANE_WORD;
         4'd7:    return LANE_STREAM;
         4'd8:    return 4'b0101;
         default: return 4'b1110;
      endcase
   endfunction

   task automatic driveIdle();
      readCtl   = '0;
      wbCtl     = '0;
      laneSel   = LANE_WORD;
      stSize    = ST_WORD;
      aluResult = '0;
      dwbDatIn  = '0;
      fslDatIn  = '0;
   endtask

   // Quiet cycles so late checks land in this test
   task automatic endTest(input string name);
      int delta;
      repeat (TAIL_LEN) begin
         @(negedge gclk);
         wbCtl.regW = '0;
         gena = 1'b1;
      end
      delta = checkFailures() - testMark;
      testMark = checkFailures();
      testCount++;
      $display("Test %-8s done, %0d failed checks", name, delta);
   endtask

   // Random operands on every data input
   task automatic randomData();
      word_t r;
      drawRandom(r);
      aluResult = r;
      drawRandom(r);
      dwbDatIn = r;
      drawRandom(r);
      fslDatIn = r;
      drawRandom(r);
      wbCtl.link = r[29:0];
      laneSel = lanePattern({1'b0, r[31:29]});
   endtask

   task automatic fillRegs();
      for (int i = 1; i < NUM_REGS; i++) begin
         @(negedge gclk);
         randomData();
         wbCtl.regW = regIdx_t'(i);
         wbCtl.src  = WB_RESULT;
      end
      endTest("fill");
   endtask

   task automatic loadLanes();
      for (int p = 0; p < LOAD_LEN; p++) begin
         @(negedge gclk);
         randomData();
         wbCtl.regW = '0;
         laneSel = lanePattern(4'(p / 4));
      end
      endTest("load");
   endtask

   // Read port A follows the previous write target
   task automatic writeRead();
      word_t   r;
      regIdx_t prevW;
      prevW = '0;
      for (int i = 0; i < WRRD_LEN; i++) begin
         @(negedge gclk);
         randomData();
         drawRandom(r);
         readCtl.regA = prevW;
         readCtl.regB = r[9:5];
         readCtl.regD = r[14:10];
         wbCtl.regW   = r[4:0];
         wbCtl.src    = r[16:15];
         prevW        = wbCtl.regW;
      end
      endTest("wrrd");
   endtask

   task automatic zeroReg();
      word_t r;
      for (int i = 0; i < R0_LEN; i++) begin
         @(negedge gclk);
         randomData();
         drawRandom(r);
         readCtl.regA = '0;
         readCtl.regB = (i % 2 == 0) ? regIdx_t'(0) : r[6:2];
         wbCtl.regW   = '0;
         wbCtl.src    = r[1:0];
      end
      endTest("r0");
   endtask

   task automatic storeFormats();
      word_t r;
      for (int i = 0; i < STORE_LEN; i++) begin
         @(negedge gclk);
         randomData();
         drawRandom(r);
         stSize       = r[1:0];
         readCtl.regA = r[6:2];
         readCtl.regD = r[11:7];
         wbCtl.regW   = '0;
      end
      endTest("store");
   endtask

   // Store operands name the register being written
   task automatic storeForward();
      word_t   r;
      regIdx_t idx;
      for (int i = 0; i < FWD_LEN; i++) begin
         @(negedge gclk);
         randomData();
         drawRandom(r);
         idx          = (r[4:0] == '0) ? regIdx_t'(1) : r[4:0];
         readCtl.regA = idx;
         readCtl.regD = idx;
         wbCtl.regW   = idx;
         wbCtl.src    = r[6:5];
         stSize       = r[8:7];
      end
      endTest("forward");
   endtask

   task automatic stallReset();
      word_t r;
      for (int i = 0; i < STALL_LEN; i++) begin
         @(negedge gclk);
         randomData();
         drawRandom(r);
         gena         = r[0];
         stSize       = r[2:1];
         readCtl.regA = r[7:3];
         readCtl.regD = r[12:8];
         wbCtl.regW   = r[17:13];
         wbCtl.src    = r[19:18];
      end
      // Reset while the store register holds data
      @(negedge gclk);
      grst = 1'b1;
      repeat (RST_LEN) @(negedge gclk);
      grst = 1'b0;
      endTest("stall");
   endtask

   initial begin
      rngState  = 32'd34;
      testCount = 0;
      testMark  = 0;
      grst      = 1'b1;
      gena      = 1'b1;
      driveIdle();
      repeat (RST_LEN) @(negedge gclk);
      grst = 1'b0;
      endTest("reset");
      fillRegs();
      loadLanes();
      writeRead();
      zeroReg();
      storeFormats();
      storeForward();
      stallReset();
      $display("Tests %0d, failed checks %0d", testCount, checkFailures());
      if (checkFailures() == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// ==== testbench/regfTb_assert.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Data path checker
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module regfTbAssert import regfPkg::*; (
   input logic     gclk,
   input logic     grst,
   input logic     gena,
   input readCtl_t readCtl_i,
   input wbCtl_t   wbCtl_i,
   input laneSel_t laneSel_i,
   input stSize_t  stSize_i,
   input word_t    aluResult_i,
   input word_t    dwbDat_i,
   input word_t    fslDat_i,
   input word_t    regA_o,
   input word_t    regB_o,
   input word_t    loadData_o,
   input word_t    dwbDat_o,
   input word_t    fslDat_o
);

   // Shadow registers, plus which entries hold a known value
   word_t               shadow [NUM_REGS];
   logic [NUM_REGS-1:0] known = '0;
   int                  failCount = 0;

   word_t expLoad;
   word_t wrModel;
   word_t fwdVal;
   word_t opA;
   word_t opD;
   word_t expStore;
   word_t storeExp = '0;
   word_t prevDwb = '0;
   word_t prevFsl = '0;
   logic  wrKnown;
   logic  hitA;
   logic  hitD;
   logic  fwdOk;
   logic  okStore;
   logic  storeArmed = 1'b0;
   logic  holdArmed = 1'b0;
   logic  rstSeen = 1'b0;

   // Load rule: one lane, a halfword, the word, or the stream word
   function automatic word_t laneExtract(laneSel_t sel, word_t bus, word_t strm);
      word_t res;
      res = '0;
      if (sel == LANE_STREAM) res = strm;
      if (sel == LANE_WORD) res = bus;
      if (sel == LANE_HI) res = {16'd0, bus[31:16]};
      if (sel == LANE_LO) res = {16'd0, bus[15:0]};
      // One-hot select picks a single byte
      for (int k = 0; k < 4; k++) begin
         if (sel == laneSel_t'(1 << k)) res = {24'd0, bus[8*k +: 8]};
      end
      return res;
   endfunction

   assign expLoad = laneExtract(laneSel_i, dwbDat_i, fslDat_i);

   // Write-back value by source
   assign wrModel = (wbCtl_i.src == WB_RESULT) ? aluResult_i :
                    (wbCtl_i.src == WB_LINK)   ? {wbCtl_i.link, 2'b00} :
                    (wbCtl_i.src == WB_LOAD)   ? expLoad : shadow[wbCtl_i.regW];
   assign wrKnown = (wbCtl_i.src != WB_KEEP) || known[wbCtl_i.regW];

   // Same-cycle hits forward only load and ALU data
   assign hitA   = (wbCtl_i.regW != '0) && (wbCtl_i.regW == readCtl_i.regA);
   assign hitD   = (wbCtl_i.regW != '0) && (wbCtl_i.regW == readCtl_i.regD);
   assign fwdOk  = (wbCtl_i.src == WB_LOAD) || (wbCtl_i.src == WB_RESULT);
   assign fwdVal = (wbCtl_i.src == WB_LOAD) ? expLoad : aluResult_i;
   assign opA    = (hitA && fwdOk) ? fwdVal : shadow[readCtl_i.regA];
   assign opD    = (hitD && fwdOk) ? fwdVal : shadow[readCtl_i.regD];

   // Lane copies by multiplication
   assign expStore = (stSize_i == ST_BYTE) ? word_t'(opD[7:0]) * 32'h0101_0101 :
                     (stSize_i == ST_HALF) ? word_t'(opD[15:0]) * 32'h0001_0001 :
                     (stSize_i == ST_WORD) ? opD : opA;
   assign okStore  = (stSize_i == ST_STREAM) ? ((hitA && fwdOk) || known[readCtl_i.regA])
                                             : ((hitD && fwdOk) || known[readCtl_i.regD]);

   // Shadow update, R0 cleared in reset only
   always @(posedge gclk) begin
      if (grst) begin
         shadow[0] <= '0;
         known[0]  <= 1'b1;
      end else if (wbCtl_i.regW != '0) begin
         shadow[wbCtl_i.regW] <= wrModel;
         known[wbCtl_i.regW]  <= wrKnown;
      end
   end

   // Expected store word and stall tracking
   always @(posedge gclk) begin
      prevDwb   <= dwbDat_o;
      prevFsl   <= fslDat_o;
      holdArmed <= !grst && !gena;
      rstSeen   <= grst;
      if (grst) begin
         storeArmed <= 1'b0;
      end else if (gena) begin
         storeArmed <= okStore;
         storeExp   <= expStore;
      end
   end

   loadCheck: assert property (@(posedge gclk) loadData_o == expLoad)
      else begin
         failCount++;
         $error("Fail %0t loadData_o exp %h act %h", $time, $sampled(expLoad),
                $sampled(loadData_o));
      end

   regACheck: assert property (@(posedge gclk) disable iff (grst)
      known[readCtl_i.regA] |-> regA_o == shadow[readCtl_i.regA])
      else begin
         failCount++;
         $error("Fail %0t regA_o exp %h act %h", $time,
                $sampled(shadow[readCtl_i.regA]), $sampled(regA_o));
      end

   regBCheck: assert property (@(posedge gclk) disable iff (grst)
      known[readCtl_i.regB] |-> regB_o == shadow[readCtl_i.regB])
      else begin
         failCount++;
         $error("Fail %0t regB_o exp %h act %h", $time,
                $sampled(shadow[readCtl_i.regB]), $sampled(regB_o));
      end

   r0Check: assert property (@(posedge gclk) disable iff (grst)
      (readCtl_i.regA == '0) |-> (regA_o == '0))
      else begin
         failCount++;
         $error("Fail %0t regA_o exp 00000000 act %h", $time, $sampled(regA_o));
      end

   storeDwbCheck: assert property (@(posedge gclk) disable iff (grst)
      storeArmed |-> dwbDat_o == storeExp)
      else begin
         failCount++;
         $error("Fail %0t dwbDat_o exp %h act %h", $time, $sampled(storeExp),
                $sampled(dwbDat_o));
      end

   storeFslCheck: assert property (@(posedge gclk) disable iff (grst)
      storeArmed |-> fslDat_o == storeExp)
      else begin
         failCount++;
         $error("Fail %0t fslDat_o exp %h act %h", $time, $sampled(storeExp),
                $sampled(fslDat_o));
      end

   holdCheck: assert property (@(posedge gclk) disable iff (grst)
      holdArmed |-> dwbDat_o == prevDwb)
      else begin
         failCount++;
         $error("Fail %0t dwbDat_o exp %h act %h", $time, $sampled(prevDwb),
                $sampled(dwbDat_o));
      end

   holdFslCheck: assert property (@(posedge gclk) disable iff (grst)
      holdArmed |-> fslDat_o == prevFsl)
      else begin
         failCount++;
         $error("Fail %0t fslDat_o exp %h act %h", $time, $sampled(prevFsl),
                $sampled(fslDat_o));
      end

   // Outputs cleared one edge into reset
   resetCheck: assert property (@(posedge gclk)
      rstSeen |-> (dwbDat_o == '0) && (fslDat_o == '0))
      else begin
         failCount++;
         $error("Fail %0t dwbDat_o/fslDat_o exp 00000000 act %h/%h", $time,
                $sampled(dwbDat_o), $sampled(fslDat_o));
      end

endmodule

// ==== rtl/regfTop.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Operand and memory data path
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module regfTop import regfPkg::*; (
   input  logic     gclk,
   input  logic     grst,
   input  logic     gena,
   input  readCtl_t readCtl_i,
   input  wbCtl_t   wbCtl_i,
   input  laneSel_t laneSel_i,
   input  stSize_t  stSize_i,
   input  word_t    aluResult_i,
   input  word_t    dwbDat_i,
   input  word_t    fslDat_i,
   output word_t    regA_o,
   output word_t    regB_o,
   output word_t    loadData_o,
   output word_t    dwbDat_o,
   output word_t    fslDat_o
);

   // Aligned load word, to write-back and store forwarding
   word_t loadData;
   // Register operands
   word_t regA;
   word_t regD;
   // Same-cycle write hits
   logic  fwdA;
   logic  fwdD;

   // Load side
   loadAlign i_loadAlign (
      .laneSel_i  (laneSel_i),
      .dwbDat_i   (dwbDat_i),
      .fslDat_i   (fslDat_i),
      .loadData_o (loadData)
   );

   // Register file, R0 cleared during reset
   regFile i_regFile (
      .gclk        (gclk),
      .grst        (grst),
      .readCtl_i   (readCtl_i),
      .wbCtl_i     (wbCtl_i),
      .aluResult_i (aluResult_i),
      .loadData_i  (loadData),
      .regA_o      (regA),
      .regB_o      (regB_o),
      .regD_o      (regD),
      .fwdA_o      (fwdA),
      .fwdD_o      (fwdD)
   );

   // Store side, one cycle behind under gena
   storeAlign i_storeAlign (
      .gclk        (gclk),
      .grst        (grst),
      .gena        (gena),
      .stSize_i    (stSize_i),
      .wbSrc_i     (wbCtl_i.src),
      .fwdA_i      (fwdA),
      .fwdD_i      (fwdD),
      .regA_i      (regA),
      .regD_i      (regD),
      .loadData_i  (loadData),
      .aluResult_i (aluResult_i),
      .dwbDat_o    (dwbDat_o),
      .fslDat_o    (fslDat_o)
   );

   assign regA_o     = regA;
   assign loadData_o = loadData;

endmodule

// ==== rtl/storeAlign.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Store aligner
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module storeAlign import regfPkg::*; (
   input  logic    gclk,
   input  logic    grst,
   input  logic    gena,
   input  stSize_t stSize_i,
   input  wbSrc_t  wbSrc_i,
   input  logic    fwdA_i,
   input  logic    fwdD_i,
   input  word_t   regA_i,
   input  word_t   regD_i,
   input  word_t   loadData_i,
   input  word_t   aluResult_i,
   output word_t   dwbDat_o,
   output word_t   fslDat_o
);

   // Forwarded operands
   word_t opA;
   word_t opD;
   // Lane-replicated store word
   word_t storeData;
   // Shared output register
   word_t storeReg;

   // A operand, feeds stream stores
   always_comb begin
      if (fwdA_i && (wbSrc_i == WB_LOAD)) begin
         opA = loadData_i;
      end else if (fwdA_i && (wbSrc_i == WB_RESULT)) begin
         opA = aluResult_i;
      end else begin
         opA = regA_i;
      end
   end

   // D operand, feeds bus stores
   always_comb begin
      if (fwdD_i && (wbSrc_i == WB_LOAD)) begin
         opD = loadData_i;
      end else if (fwdD_i && (wbSrc_i == WB_RESULT)) begin
         opD = aluResult_i;
      end else begin
         opD = regD_i;
      end
   end

   // Copy the operand across the byte lanes
   always_comb begin
      case (stSize_i)
         // Low byte on every lane
         ST_BYTE:   storeData = {4{opD[7:0]}};
         // Low halfword on both halves
         ST_HALF:   storeData = {2{opD[15:0]}};
         ST_WORD:   storeData = opD;
         // Stream put uses the A operand
         ST_STREAM: storeData = opA;
         default:   storeData = opD;
      endcase
   end

   // Holds while the pipeline is stalled
   always_ff @(posedge gclk) begin
      if (grst) begin
         storeReg <= '0;
      end else if (gena) begin
         storeReg <= storeData;
      end
   end

   // Both ports see the same word
   assign dwbDat_o = storeReg;
   assign fslDat_o = storeReg;

endmodule

// ==== rtl/regFile.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Register file R0-R31
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module regFile import regfPkg::*; (
   input  logic     gclk,
   input  logic     grst,
   input  readCtl_t readCtl_i,
   input  wbCtl_t   wbCtl_i,
   input  word_t    aluResult_i,
   input  word_t    loadData_i,
   output word_t    regA_o,
   output word_t    regB_o,
   output word_t    regD_o,
   output logic     fwdA_o,
   output logic     fwdD_o
);

   // One array copy per read port, LUT-RAM style
   word_t ramA [NUM_REGS];
   word_t ramB [NUM_REGS];
   word_t ramD [NUM_REGS];

   // Write-back data path
   word_t   oldValue;
   word_t   wbData;
   word_t   wrData;
   regIdx_t wrIdx;
   logic    wrNonZero;
   logic    wrEn;

   // Combinational reads
   assign regA_o = ramA[readCtl_i.regA];
   assign regB_o = ramB[readCtl_i.regB];
   assign regD_o = ramD[readCtl_i.regD];

   // Current contents of the target register
   assign oldValue = ramD[wbCtl_i.regW];

   // Source mux
   always_comb begin
      case (wbCtl_i.src)
         WB_RESULT: wbData = aluResult_i;
         // Link address is word aligned
         WB_LINK:   wbData = {wbCtl_i.link, 2'b00};
         WB_LOAD:   wbData = loadData_i;
         // Rewrites the old value, no change
         WB_KEEP:   wbData = oldValue;
         default:   wbData = oldValue;
      endcase
   end

   // R0 is never a write target
   assign wrNonZero = |wbCtl_i.regW;

   // During reset the port clears R0 instead
   assign wrIdx  = grst ? regIdx_t'(0) : wbCtl_i.regW;
   assign wrData = grst ? word_t'(0) : wbData;
   assign wrEn   = grst | wrNonZero;

   // All three copies written together, gena does not apply
   always @(posedge gclk) begin
      if (wrEn) begin
         ramA[wrIdx] <= wrData;
         ramB[wrIdx] <= wrData;
         ramD[wrIdx] <= wrData;
      end
   end

   // Same-cycle write hits for the store side
   assign fwdA_o = wrNonZero && (readCtl_i.regA == wbCtl_i.regW);
   assign fwdD_o = wrNonZero && (readCtl_i.regD == wbCtl_i.regW);

   // Random power-up contents, as real memory would show
   initial begin
      for (int i = 0; i < NUM_REGS; i++) begin
         ramA[i] = $urandom;
         ramB[i] = $urandom;
         ramD[i] = $urandom;
      end
   end

endmodule

// ==== rtl/loadAlign.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Load aligner
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module loadAlign import regfPkg::*; (
   input  laneSel_t laneSel_i,
   input  word_t    dwbDat_i,
   input  word_t    fslDat_i,
   output word_t    loadData_o
);

   // Byte lanes of the bus word, MSB lane first
   logic [7:0]  busB3;
   logic [7:0]  busB2;
   logic [7:0]  busB1;
   logic [7:0]  busB0;
   // Halfwords of the bus word
   logic [15:0] busHi;
   logic [15:0] busLo;
   word_t       alignData;

   assign busB3 = dwbDat_i[31:24];
   assign busB2 = dwbDat_i[23:16];
   assign busB1 = dwbDat_i[15:8];
   assign busB0 = dwbDat_i[7:0];
   assign busHi = dwbDat_i[31:16];
   assign busLo = dwbDat_i[15:0];

   // Lane select decode, all results zero-extended
   always_comb begin
      case (laneSel_i)
         // Single bytes
         LANE_B3:     alignData = {24'd0, busB3};
         LANE_B2:     alignData = {24'd0, busB2};
         LANE_B1:     alignData = {24'd0, busB1};
         LANE_B0:     alignData = {24'd0, busB0};
         // Halfwords
         LANE_HI:     alignData = {16'd0, busHi};
         LANE_LO:     alignData = {16'd0, busLo};
         // Full word straight through
         LANE_WORD:   alignData = dwbDat_i;
         // No lanes selected means a stream read
         LANE_STREAM: alignData = fslDat_i;
         // Illegal patterns
         default:     alignData = '0;
      endcase
   end

   // Purely combinational, same-cycle result
   assign loadData_o = alignData;

endmodule

// ==== rtl/regfPkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Register file types
// ~~~~~~~~~~~~~~~~~~~~
package regfPkg;

   // Basic widths
   localparam int WORD_W    = 32;
   localparam int REG_IDX_W = 5;
   localparam int NUM_REGS  = 32;
   localparam int LANE_W    = 4;
   localparam int LINK_W    = 30;

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [REG_IDX_W-1:0] regIdx_t;
   typedef logic [LANE_W-1:0]    laneSel_t;
   // Link address without the two low zero bits
   typedef logic [LINK_W-1:0]    pcLink_t;
   typedef logic [1:0]           wbSrc_t;
   typedef logic [1:0]           stSize_t;

   // Byte-lane patterns, MSB lane first
   localparam laneSel_t LANE_B3     = 4'b1000;
   localparam laneSel_t LANE_B2     = 4'b0100;
   localparam laneSel_t LANE_B1     = 4'b0010;
   localparam laneSel_t LANE_B0     = 4'b0001;
   localparam laneSel_t LANE_HI     = 4'b1100;
   localparam laneSel_t LANE_LO     = 4'b0011;
   localparam laneSel_t LANE_WORD   = 4'b1111;
   localparam laneSel_t LANE_STREAM = 4'b0000;

   // Write-back sources
   localparam wbSrc_t WB_RESULT = 2'd0;
   localparam wbSrc_t WB_LINK   = 2'd1;
   localparam wbSrc_t WB_LOAD   = 2'd2;
   localparam wbSrc_t WB_KEEP   = 2'd3;

   // Store sizes
   localparam stSize_t ST_BYTE   = 2'd0;
   localparam stSize_t ST_HALF   = 2'd1;
   localparam stSize_t ST_WORD   = 2'd2;
   localparam stSize_t ST_STREAM = 2'd3;

   // Read port indices
   typedef struct packed {
      regIdx_t regA;
      regIdx_t regB;
      regIdx_t regD;
   } readCtl_t;

   // Write-back control
   typedef struct packed {
      regIdx_t regW;
      wbSrc_t  src;
      pcLink_t link;
   } wbCtl_t;

endpackage
